/* dac_interface.f */
hdl/dac_sample_pkg.sv
hdl/dac_cfg_pkg.sv
hdl/xfer_if.sv
hdl/cmd_link.sv
hdl/dac_cmd_ctrl.sv
hdl/sample_gen.sv
hdl/dac_interface.sv
verif/dac_interface_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP := dac_interface_tb
FILELIST := dac_interface.f
VFLAGS := --binary --timing --assert -j 0 -Wno-fatal
OBJDIR := obj_dir
PASS_MSG := Simulation PASSED

SIM_BIN := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* verif/dac_interface_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_interface_tb;

	import dac_cfg_pkg::*;
	import dac_sample_pkg::*;

	localparam int clk_half = 2;
	localparam int reset_cycles = 10;
	localparam int cmd_cycles = 40;
	localparam int shift_cycles = 600;
	localparam int wave_cycles = 22000;
	localparam int scale_cycles = 400;
	localparam int halt_cycles = 60;
	localparam int resume_cycles = 400;
	// six commands cross the links during the run
	localparam int total_cycles = reset_cycles + 6 * cmd_cycles + shift_cycles + wave_cycles
		+ scale_cycles + halt_cycles + resume_cycles;
	localparam int watchdog_cycles = total_cycles + total_cycles / 8 + 200;

	logic ps_clk;
	logic ps_rst;
	logic [mem_size-1:0] fresh_bits;
	logic [mem_size-1:0][wd_width-1:0] read_resps;
	logic [scale_width-1:0] scale_factor;
	logic halt;
	logic dac_rdy;
	batch_t dac_batch;
	logic valid_dac_batch;
	mode_t dac_mode;

	logic [31:0] lfsr_state;
	logic rdy_prev;
	// reference model of the generator
	mode_t model_mode;
	sample_t model_lanes [batch_samples];
	sample_t model_base;
	logic [scale_width-1:0] model_scale;
	logic base_wrapped;

	dac_interface uut (
		.ps_clk(ps_clk),
		.ps_rst(ps_rst),
		.fresh_bits(fresh_bits),
		.read_resps(read_resps),
		.scale_factor(scale_factor),
		.halt(halt),
		.dac_rdy(dac_rdy),
		.dac_batch(dac_batch),
		.valid_dac_batch(valid_dac_batch),
		.dac_mode(dac_mode)
	);

	always #(clk_half) ps_clk = ~ps_clk;

	task automatic stop_failed();
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic report_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		stop_failed();
	endtask

	// a batch only follows a cycle with dac_rdy high
	assert property (@(posedge ps_clk) disable iff (ps_rst) valid_dac_batch |-> $past(dac_rdy))
		else report_value("valid after dac_rdy", 64'd0, 64'($sampled(valid_dac_batch)));

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one LFSR step per bit taken
	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
	endtask

	function automatic sample_t lane_step(input sample_t v);
		return v[0] ? ((v >> 1) ^ 16'hB400) : (v >> 1);
	endfunction

	// expected batch for one accepted dac_rdy cycle, then advance the model
	task automatic model_batch(output logic [63:0] expected);
		sample_t v;
		sample_t next_base;
		for (int i = 0; i < batch_samples; i++) begin
			if (model_mode == mode_shift) begin
				model_lanes[i] = lane_step(model_lanes[i]);
				v = model_lanes[i];
			end else begin
				v = model_base + sample_t'(i);
			end
			expected[i*sample_width +: sample_width] = v >> model_scale;
		end
		if (model_mode == mode_wave) begin
			next_base = model_base + sample_t'(batch_samples);
			if (next_base < model_base) begin
				base_wrapped = 1'b1;
			end
			model_base = next_base;
		end
	endtask

	task automatic check_batch(input string name);
		logic [63:0] expected;
		if (rdy_prev && model_mode != mode_stopped) begin
			model_batch(expected);
			assert (valid_dac_batch === 1'b1)
				else report_value({name, " valid"}, 64'd1, 64'(valid_dac_batch));
			assert (dac_batch === expected)
				else report_value(name, expected, dac_batch);
		end else begin
			assert (valid_dac_batch === 1'b0)
				else report_value({name, " valid"}, 64'd0, 64'(valid_dac_batch));
		end
	endtask

	// kind 0 random, 1 mostly ready, 2 always ready
	task automatic run_stream(input int cycles, input int kind, input string name);
		logic [31:0] bits;
		for (int c = 0; c <= cycles; c++) begin
			@(negedge ps_clk);
			check_batch(name);
			if (c == cycles) begin
				dac_rdy = 1'b0;
			end else if (kind == 0) begin
				take_bits(1, bits);
				dac_rdy = bits[0];
			end else if (kind == 1) begin
				take_bits(3, bits);
				dac_rdy = (bits[2:0] != 3'b000);
			end else begin
				dac_rdy = 1'b1;
			end
			rdy_prev = dac_rdy;
		end
	endtask

	// every command, scale-only ones too, ends with a mode response
	task automatic wait_readback(input mode_t expected, input string name);
		@(negedge ps_clk);
		while (!uut.resp_out_valid) begin
			@(negedge ps_clk);
		end
		@(negedge ps_clk);
		assert (dac_mode === expected)
			else report_value(name, 64'(expected), 64'(dac_mode));
	endtask

	task automatic pulse_fresh(input int id);
		@(negedge ps_clk);
		fresh_bits[id] = 1'b1;
		@(negedge ps_clk);
		fresh_bits[id] = 1'b0;
	endtask

	task automatic load_seeds();
		logic [31:0] word;
		for (int i = 0; i < batch_samples; i++) begin
			take_bits(32, word);
			read_resps[seed_base_id + i] = word;
			model_lanes[i] = word[sample_width-1:0];
		end
	endtask

	initial begin
		#(watchdog_cycles * 2 * clk_half);
		$display("watchdog: run still busy after %0d cycles, looks hung", watchdog_cycles);
		stop_failed();
	end

	initial begin
		ps_clk = 1'b0;
		ps_rst = 1'b1;
		fresh_bits = '0;
		read_resps = '0;
		scale_factor = '0;
		halt = 1'b0;
		dac_rdy = 1'b0;
		rdy_prev = 1'b0;
		lfsr_state = 32'd67654;
		model_mode = mode_stopped;
		model_base = '0;
		model_scale = '0;
		base_wrapped = 1'b0;
		for (int i = 0; i < batch_samples; i++) begin
			model_lanes[i] = '0;
		end
		repeat (reset_cycles) @(negedge ps_clk);
		ps_rst = 1'b0;
		@(negedge ps_clk);
		assert (valid_dac_batch === 1'b0)
			else report_value("reset valid", 64'd0, 64'(valid_dac_batch));
		// controller sends its own reset command first
		wait_readback(mode_stopped, "reset mode");

		load_seeds();
		pulse_fresh(seed_valid_id);
		wait_readback(mode_shift, "shift mode");
		model_mode = mode_shift;
		run_stream(shift_cycles, 0, "shift batch");

		pulse_fresh(trig_wave_id);
		wait_readback(mode_wave, "wave mode");
		model_mode = mode_wave;
		model_base = '0;
		run_stream(wave_cycles, 1, "wave batch");
		assert (base_wrapped)
			else begin
				$display("wave ramp never wrapped past 16 bits");
				stop_failed();
			end

		@(negedge ps_clk);
		scale_factor = 4'd5;
		wait_readback(mode_wave, "scale mode");
		model_scale = scale_factor;
		run_stream(scale_cycles, 0, "scaled wave batch");

		@(negedge ps_clk);
		halt = 1'b1;
		wait_readback(mode_stopped, "halt mode");
		model_mode = mode_stopped;
		run_stream(halt_cycles, 2, "halt batch");
		@(negedge ps_clk);
		halt = 1'b0;

		load_seeds();
		pulse_fresh(seed_valid_id);
		wait_readback(mode_shift, "resume mode");
		model_mode = mode_shift;
		run_stream(resume_cycles, 0, "resume batch");

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/dac_interface.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_interface (
	input logic ps_clk,
	input logic ps_rst,
	input logic [dac_cfg_pkg::mem_size-1:0] fresh_bits,
	input logic [dac_cfg_pkg::mem_size-1:0][dac_cfg_pkg::wd_width-1:0] read_resps,
	input logic [dac_sample_pkg::scale_width-1:0] scale_factor,
	input logic halt,
	input logic dac_rdy,
	output dac_sample_pkg::batch_t dac_batch,
	output logic valid_dac_batch,
	output dac_cfg_pkg::mode_t dac_mode
);

	import dac_cfg_pkg::*;

	ps_cmd_t cmd_out;
	logic cmd_out_valid;
	dac_resp_t resp_out;
	logic resp_out_valid;

	xfer_if #(.payload_t(ps_cmd_t)) cmd_if ();
	xfer_if #(.payload_t(dac_resp_t)) resp_if ();

	dac_cmd_ctrl ctrl (
		.ps_clk(ps_clk),
		.ps_rst(ps_rst),
		.fresh_bits(fresh_bits),
		.read_resps(read_resps),
		.scale_factor(scale_factor),
		.halt(halt),
		.cmd(cmd_if.producer),
		.resp_valid(resp_out_valid),
		.resp(resp_out),
		.dac_mode(dac_mode)
	);

	cmd_link #(.payload_t(ps_cmd_t)) cmd_xfer (
		.ps_clk(ps_clk),
		.ps_rst(ps_rst),
		.src(cmd_if.link),
		.out_valid(cmd_out_valid),
		.out_data(cmd_out)
	);

	// mode readback from the generator
	cmd_link #(.payload_t(dac_resp_t)) resp_xfer (
		.ps_clk(ps_clk),
		.ps_rst(ps_rst),
		.src(resp_if.link),
		.out_valid(resp_out_valid),
		.out_data(resp_out)
	);

	sample_gen gen (
		.ps_clk(ps_clk),
		.ps_rst(ps_rst),
		.cmd_valid(cmd_out_valid),
		.cmd(cmd_out),
		.dac_rdy(dac_rdy),
		.resp_rdy(resp_if.rdy),
		.resp_valid(resp_if.valid),
		.resp(resp_if.data),
		.dac_batch(dac_batch),
		.valid_dac_batch(valid_dac_batch)
	);

endmodule

`default_nettype wire

/* hdl/sample_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_gen (
	input logic ps_clk,
	input logic ps_rst,
	input logic cmd_valid,
	input dac_cfg_pkg::ps_cmd_t cmd,
	input logic dac_rdy,
	input logic resp_rdy,
	output logic resp_valid,
	output dac_cfg_pkg::dac_resp_t resp,
	output dac_sample_pkg::batch_t dac_batch,
	output logic valid_dac_batch
);

	import dac_cfg_pkg::*;
	import dac_sample_pkg::*;

	mode_t mode;
	mode_t mode_next;
	logic [scale_width-1:0] scale;
	sample_t base;
	batch_t lanes;
	batch_t lanes_step;
	batch_t batch_next;
	sample_t raw;
	logic load_batch;
	logic resp_pend;
	logic resp_go;

	// a command in the same cycle wins over batch generation
	assign load_batch = !cmd_valid && dac_rdy && (mode != mode_stopped);
	assign resp_go = (cmd_valid || resp_pend) && resp_rdy && !resp_valid;

	always_comb begin
		mode_next = mode;
		if (cmd_valid) begin
			case (cmd.code)
				cmd_run_shift: mode_next = mode_shift;
				cmd_run_wave: mode_next = mode_wave;
				cmd_halt, cmd_reset: mode_next = mode_stopped;
				default: ;
			endcase
		end
	end

	always_comb begin
		raw = '0;
		for (int i = 0; i < batch_samples; i++) begin
			lanes_step[i] = (lanes[i] >> 1) ^ (lanes[i][0] ? lfsr_taps : '0);
			if (mode == mode_shift) begin
				raw = lanes_step[i];
			end else begin
				raw = base + sample_t'(i);
			end
			batch_next[i] = raw >> scale;
		end
	end

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			mode <= mode_stopped;
			scale <= '0;
			base <= '0;
			lanes <= '0;
			valid_dac_batch <= 1'b0;
			resp_valid <= 1'b0;
			resp_pend <= 1'b0;
		end else begin
			mode <= mode_next;
			valid_dac_batch <= load_batch;
			if (cmd_valid) begin
				scale <= cmd.scale;
				case (cmd.code)
					cmd_run_shift: lanes <= cmd.seeds;
					cmd_run_wave: base <= '0;
					cmd_reset: begin
						lanes <= '0;
						base <= '0;
						scale <= '0;
					end
					default: ;
				endcase
			end else if (load_batch) begin
				if (mode == mode_shift) begin
					lanes <= lanes_step;
				end else begin
					base <= base + sample_t'(batch_samples);
				end
			end
			// response holds for one cycle, the link is idle whenever it is offered
			if (resp_valid && resp_rdy) begin
				resp_valid <= 1'b0;
			end
			if (resp_go) begin
				resp_valid <= 1'b1;
			end
			resp_pend <= (cmd_valid || resp_pend) && !resp_go;
		end
	end

	always_ff @(posedge ps_clk) begin
		if (load_batch) begin
			dac_batch <= batch_next;
		end
		if (resp_go) begin
			resp <= '{mode: mode_next};
		end
	end

endmodule

`default_nettype wire

/* hdl/dac_cmd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_cmd_ctrl (
	input logic ps_clk,
	input logic ps_rst,
	input logic [dac_cfg_pkg::mem_size-1:0] fresh_bits,
	input logic [dac_cfg_pkg::mem_size-1:0][dac_cfg_pkg::wd_width-1:0] read_resps,
	input logic [dac_sample_pkg::scale_width-1:0] scale_factor,
	input logic halt,
	xfer_if.producer cmd,
	input logic resp_valid,
	input dac_cfg_pkg::dac_resp_t resp,
	output dac_cfg_pkg::mode_t dac_mode
);

	import dac_cfg_pkg::*;
	import dac_sample_pkg::*;

	typedef enum logic [1:0] {st_idle, st_send, st_reset_dac, st_halt_dac} state_t;

	state_t state;
	cmd_code_t cmd_code;
	cmd_code_t issue_code;
	logic issue;
	logic [scale_width-1:0] cmd_scale;
	logic [scale_width-1:0] scale_q;
	logic scale_diff;
	logic scale_changed;
	logic halt_q;
	logic halt_rise;
	logic halt_pend;
	batch_t seed_set;
	batch_t read_seeds;

	assign scale_diff = (scale_factor != scale_q);
	assign halt_rise = halt && !halt_q;

	assign cmd.data = '{code: cmd_code, scale: cmd_scale, seeds: seed_set};

	always_comb begin
		for (int i = 0; i < batch_samples; i++) begin
			read_seeds[i] = read_resps[seed_base_id + i][sample_width-1:0];
		end
	end

	// which command, if any, goes out this cycle
	always_comb begin
		issue = 1'b0;
		issue_code = cmd_none;
		case (state)
			st_idle: begin
				if (!halt && !halt_pend && cmd.rdy) begin
					if (fresh_bits[seed_valid_id]) begin
						issue = 1'b1;
						issue_code = cmd_run_shift;
					end else if (fresh_bits[trig_wave_id]) begin
						issue = 1'b1;
						issue_code = cmd_run_wave;
					end else if (scale_changed || scale_diff) begin
						issue = 1'b1;
					end
				end
			end
			st_reset_dac: begin
				issue = cmd.rdy;
				issue_code = cmd_reset;
			end
			st_halt_dac: begin
				issue = cmd.rdy;
				issue_code = cmd_halt;
			end
			default: ;
		endcase
	end

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			state <= st_reset_dac;
			cmd.valid <= 1'b0;
			cmd_code <= cmd_none;
			cmd_scale <= '0;
			seed_set <= '0;
			scale_q <= '0;
			scale_changed <= 1'b0;
			halt_q <= 1'b0;
			halt_pend <= 1'b0;
			dac_mode <= mode_stopped;
		end else begin
			scale_q <= scale_factor;
			halt_q <= halt;
			if (resp_valid) begin
				dac_mode <= resp.mode;
			end
			if (scale_diff) begin
				scale_changed <= 1'b1;
			end
			if (issue) begin
				cmd.valid <= 1'b1;
				cmd_code <= issue_code;
				cmd_scale <= scale_factor;
				state <= st_send;
				// the generator zeroes its scale on reset, so keep the change pending
				if (issue_code != cmd_reset) begin
					scale_changed <= 1'b0;
				end
				if (issue_code == cmd_halt) begin
					halt_pend <= 1'b0;
				end
				if (issue_code == cmd_run_shift) begin
					seed_set <= read_seeds;
				end
			end else if (state == st_idle && (halt_rise || halt_pend)) begin
				state <= st_halt_dac;
			end
			if (halt_rise) begin
				halt_pend <= 1'b1;
			end
			if (cmd.valid && cmd.rdy) begin
				cmd.valid <= 1'b0;
			end
			if (state == st_send && cmd.done) begin
				state <= st_idle;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/cmd_link.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_link #(
	parameter type payload_t = logic
) (
	input logic ps_clk,
	input logic ps_rst,
	xfer_if.link src,
	output logic out_valid,
	output payload_t out_data
);

	typedef enum logic [1:0] {src_idle, src_req, src_release} src_state_t;
	typedef enum logic {dst_idle, dst_ack} dst_state_t;

	src_state_t src_state;
	dst_state_t dst_state;
	logic req;
	logic ack;
	payload_t held_data;

	// one item in flight, so the link is free only when idle
	assign src.rdy = (src_state == src_idle);

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			src_state <= src_idle;
			req <= 1'b0;
			src.done <= 1'b0;
		end else begin
			src.done <= 1'b0;
			case (src_state)
				src_idle: begin
					if (src.valid) begin
						req <= 1'b1;
						src_state <= src_req;
					end
				end
				src_req: begin
					if (ack) begin
						req <= 1'b0;
						src_state <= src_release;
					end
				end
				src_release: begin
					// wait for ack to drop before freeing the link
					if (!ack) begin
						src.done <= 1'b1;
						src_state <= src_idle;
					end
				end
				default: src_state <= src_idle;
			endcase
		end
	end

	always_ff @(posedge ps_clk) begin
		if (src_state == src_idle && src.valid) begin
			held_data <= src.data;
		end
	end

	// consumer side
	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			dst_state <= dst_idle;
			ack <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			case (dst_state)
				dst_idle: begin
					if (req) begin
						ack <= 1'b1;
						out_valid <= 1'b1;
						dst_state <= dst_ack;
					end
				end
				dst_ack: begin
					if (!req) begin
						ack <= 1'b0;
						dst_state <= dst_idle;
					end
				end
				default: dst_state <= dst_idle;
			endcase
		end
	end

	always_ff @(posedge ps_clk) begin
		if (dst_state == dst_idle && req) begin
			out_data <= held_data;
		end
	end

endmodule

`default_nettype wire

/* hdl/xfer_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface xfer_if #(
	parameter type payload_t = logic
);

	logic valid;
	logic rdy;
	logic done;
	payload_t data;

	// producer offers data while rdy, holds it until done
	modport producer (
		output valid,
		output data,
		input rdy,
		input done
	);

	modport link (
		input valid,
		input data,
		output rdy,
		output done
	);

endinterface

`default_nettype wire

/* hdl/dac_cfg_pkg.sv */
`default_nettype none

package dac_cfg_pkg;

	// register window seen by the controller
	localparam int wd_width = 32;
	localparam int mem_size = 16;

	// fresh bits that raise controller events
	localparam int trig_wave_id = 1;
	localparam int seed_valid_id = 2;

	// four seed words start here, seed in the low half
	localparam int seed_base_id = 4;

	typedef enum logic [2:0] {
		cmd_none,
		cmd_run_shift,
		cmd_run_wave,
		cmd_halt,
		cmd_reset
	} cmd_code_t;

	typedef enum logic [1:0] {
		mode_stopped,
		mode_shift,
		mode_wave
	} mode_t;

	typedef struct packed {
		cmd_code_t code;
		logic [dac_sample_pkg::scale_width-1:0] scale;
		dac_sample_pkg::batch_t seeds;
	} ps_cmd_t;

	typedef struct packed {
		mode_t mode;
	} dac_resp_t;

endpackage

`default_nettype wire

/* hdl/dac_sample_pkg.sv */
`default_nettype none

package dac_sample_pkg;

	// one DAC sample and the batch handed to the DAC per ready cycle
	localparam int sample_width = 16;
	localparam int batch_samples = 4;

	// right-shift amount applied to every output sample
	localparam int scale_width = 4;

	typedef logic [sample_width-1:0] sample_t;

	// lane 0 sits in the low bits
	typedef logic [batch_samples-1:0][sample_width-1:0] batch_t;

	// galois feedback taps for the per-lane LFSR
	localparam sample_t lfsr_taps = 16'hB400;

endpackage

`default_nettype wire
